//--- logic/jesd_rx_pkg.sv
`default_nettype none

package jesd_rx_pkg;

  // ***********************************************************
  // Link geometry
  // ***********************************************************
  localparam int NUM_LANES       = 2;
  localparam int OCTETS_PER_BEAT = 4;
  localparam int BEAT_BITS       = 8 * OCTETS_PER_BEAT;
  localparam int LMFC_W          = 8;  // LMFC counter width

  localparam logic [7:0] K28_5 = 8'hBC;  // CGS comma

  localparam int CGS_GOOD_BEATS = 4;
  localparam int CGS_LOSS_BEATS = 3;

  localparam int BUFFER_DEPTH = 16;
  localparam int BUF_AW       = $clog2(BUFFER_DEPTH);

  // ***********************************************************
  // Types
  // ***********************************************************

  // One lane beat, seen as a word or as octets
  typedef union packed {
    logic [BEAT_BITS-1:0]                word;
    logic [OCTETS_PER_BEAT-1:0][7:0]     octet;
  } beat_u;

  typedef struct packed {
    beat_u                       data;
    logic [OCTETS_PER_BEAT-1:0]  charisk;
    logic [OCTETS_PER_BEAT-1:0]  disperr;
    logic [OCTETS_PER_BEAT-1:0]  notintable;
  } phy_lane_t;

  typedef struct packed {
    logic [NUM_LANES-1:0] lanes_disable;
    logic [7:0]           octets_per_frame;       // 1, 2 or 4
    logic [9:0]           octets_per_multiframe;  // Multiple of 4, max 64
    logic [7:0]           lmfc_offset;
    logic [7:0]           buffer_delay;
    logic                 buffer_early_release;
  } rx_cfg_t;

  typedef enum logic [1:0] {
    ST_RESET = 2'd0,
    ST_CGS   = 2'd1,
    ST_IFS   = 2'd2,
    ST_DATA  = 2'd3
  } ctrl_state_e;

  typedef enum logic [1:0] {
    CGS_INIT  = 2'd0,
    CGS_CHECK = 2'd1,
    CGS_DATA  = 2'd2
  } cgs_state_e;

  typedef struct packed {
    logic                                 valid;
    logic [NUM_LANES-1:0][BEAT_BITS-1:0]  data;
    logic [OCTETS_PER_BEAT-1:0]           sof;
    logic [OCTETS_PER_BEAT-1:0]           eof;
    logic [OCTETS_PER_BEAT-1:0]           somf;
    logic [OCTETS_PER_BEAT-1:0]           eomf;
  } rx_out_t;

endpackage

`default_nettype wire

//--- logic/lmfc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module lmfc_gen (
  input  wire                              clk,
  input  wire                              device_reset,
  input  wire                              i_sysref,
  input  jesd_rx_pkg::rx_cfg_t             i_cfg,
  output logic                             o_lmfc_edge,
  output logic [jesd_rx_pkg::LMFC_W-1:0]   o_lmfc_counter,
  output logic                             o_sysref_alignment_error
);

  logic [jesd_rx_pkg::LMFC_W-1:0] beats;
  logic [jesd_rx_pkg::LMFC_W-1:0] last_beat;
  logic [jesd_rx_pkg::LMFC_W-1:0] expected;  // Counter value a matching edge sees
  logic [jesd_rx_pkg::LMFC_W-1:0] counter;
  logic                           sysref_r;
  logic                           sysref_d;
  logic                           sysref_edge;
  logic                           sysref_seen;

  assign beats = jesd_rx_pkg::LMFC_W'(i_cfg.octets_per_multiframe /
                                       jesd_rx_pkg::OCTETS_PER_BEAT);
  assign last_beat = beats - 1'b1;

  // One beat before the offset, wrapping at the multiframe
  assign expected = (i_cfg.lmfc_offset == '0) ? last_beat : i_cfg.lmfc_offset - 1'b1;

  assign sysref_edge = sysref_r & ~sysref_d;

  always_ff @(posedge clk) begin
    if (device_reset) begin
      sysref_r                 <= 1'b0;
      sysref_d                 <= 1'b0;
      sysref_seen              <= 1'b0;
      counter                  <= last_beat;  // First edge one beat after reset
      o_sysref_alignment_error <= 1'b0;
    end else begin
      sysref_r <= i_sysref;
      sysref_d <= sysref_r;
      o_sysref_alignment_error <= sysref_edge & sysref_seen & (counter != expected);
      if (sysref_edge) begin
        counter     <= i_cfg.lmfc_offset;
        sysref_seen <= 1'b1;
      end else if (counter == last_beat) begin
        counter <= '0;
      end else begin
        counter <= counter + 1'b1;
      end
    end
  end

  assign o_lmfc_counter = counter;
  assign o_lmfc_edge    = (counter == '0);

endmodule

`default_nettype wire

//--- logic/rx_link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rx_link_ctrl (
  input  wire                                  clk,
  input  wire                                  device_reset,
  input  jesd_rx_pkg::rx_cfg_t                 i_cfg,
  input  wire                                  i_lmfc_edge,
  input  wire [jesd_rx_pkg::LMFC_W-1:0]        i_lmfc_counter,
  input  wire [jesd_rx_pkg::NUM_LANES-1:0]     i_cgs_ready,
  input  wire [jesd_rx_pkg::NUM_LANES-1:0]     i_buffer_ready,
  output logic                                 o_sync,
  output logic [jesd_rx_pkg::NUM_LANES-1:0]    o_cgs_reset,
  output logic                                 o_ifs_reset,
  output logic                                 o_release_n,
  output logic                                 o_valid,
  output jesd_rx_pkg::ctrl_state_e             o_ctrl_state,
  output logic                                 o_unexpected_lane_state_error
);

  jesd_rx_pkg::ctrl_state_e state;

  logic all_cgs_ready;
  logic all_buffer_ready;
  logic link_up;
  logic lane_lost;
  logic lane_lost_d;
  logic release_opp;

  // Disabled lanes always count as good
  assign all_cgs_ready    = &(i_cgs_ready | i_cfg.lanes_disable);
  assign all_buffer_ready = &(i_buffer_ready | i_cfg.lanes_disable);

  assign link_up   = (state == jesd_rx_pkg::ST_IFS) || (state == jesd_rx_pkg::ST_DATA);
  assign lane_lost = link_up & ~all_cgs_ready;

  assign release_opp = (i_lmfc_counter == i_cfg.buffer_delay) | i_cfg.buffer_early_release;

  // ***********************************************************
  // Link state machine
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (device_reset) begin
      state <= jesd_rx_pkg::ST_RESET;
    end else begin
      case (state)
        jesd_rx_pkg::ST_RESET: state <= jesd_rx_pkg::ST_CGS;
        jesd_rx_pkg::ST_CGS: begin
          if (all_cgs_ready && i_lmfc_edge) state <= jesd_rx_pkg::ST_IFS;
        end
        jesd_rx_pkg::ST_IFS: begin
          if (lane_lost) begin
            state <= jesd_rx_pkg::ST_CGS;
          end else if (all_buffer_ready) begin
            state <= jesd_rx_pkg::ST_DATA;
          end
        end
        default: begin
          if (lane_lost) state <= jesd_rx_pkg::ST_CGS;
        end
      endcase
    end
  end

  // Release holds until the link drops back
  always_ff @(posedge clk) begin
    if (device_reset) begin
      o_release_n <= 1'b1;
      o_valid     <= 1'b0;
      lane_lost_d <= 1'b0;
    end else begin
      if (!link_up) begin
        o_release_n <= 1'b1;
      end else if (release_opp && all_buffer_ready && !lane_lost) begin
        o_release_n <= 1'b0;
      end
      o_valid     <= ~o_release_n;  // Read data is one cycle behind
      lane_lost_d <= lane_lost;
    end
  end

  assign o_sync       = link_up;
  assign o_ifs_reset  = ~link_up;
  assign o_cgs_reset  = {jesd_rx_pkg::NUM_LANES{state == jesd_rx_pkg::ST_RESET}} |
                        i_cfg.lanes_disable;
  assign o_ctrl_state = state;

  assign o_unexpected_lane_state_error = lane_lost & ~lane_lost_d;

endmodule

`default_nettype wire

//--- logic/lane_cgs.sv
`timescale 1ns/1ps
`default_nettype none

module lane_cgs (
  input  wire                     clk,
  input  wire                     i_cgs_reset,
  input  wire                     i_ifs_reset,
  input  jesd_rx_pkg::phy_lane_t  i_phy,
  output logic                    o_cgs_ready,
  output jesd_rx_pkg::cgs_state_e o_cgs_state,
  output logic                    o_frame_start
);

  jesd_rx_pkg::cgs_state_e state;

  logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0] is_comma;
  logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0] octet_err;
  logic                                    comma_beat;
  logic                                    err_beat;
  logic                                    user_beat;
  logic [2:0]                              good_cnt;
  logic [2:0]                              err_cnt;
  logic                                    frame_seen;

  always_comb begin
    for (int k = 0; k < jesd_rx_pkg::OCTETS_PER_BEAT; k++) begin
      is_comma[k] = i_phy.charisk[k] && (i_phy.data.octet[k] == jesd_rx_pkg::K28_5);
    end
  end

  assign octet_err  = i_phy.disperr | i_phy.notintable;
  assign comma_beat = (&is_comma) & ~(|octet_err);  // Clean all-comma beat
  assign err_beat   = |octet_err;
  assign user_beat  = ~i_phy.charisk[0];

  // ***********************************************************
  // Code group sync
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (i_cgs_reset) begin
      state    <= jesd_rx_pkg::CGS_INIT;
      good_cnt <= '0;
      err_cnt  <= '0;
    end else begin
      case (state)
        jesd_rx_pkg::CGS_INIT: begin
          if (!comma_beat) begin
            good_cnt <= '0;
          end else if (good_cnt == 3'(jesd_rx_pkg::CGS_GOOD_BEATS - 1)) begin
            state    <= jesd_rx_pkg::CGS_DATA;
            good_cnt <= '0;
          end else begin
            good_cnt <= good_cnt + 1'b1;
          end
        end
        jesd_rx_pkg::CGS_DATA: begin
          if (err_beat) begin
            state   <= jesd_rx_pkg::CGS_CHECK;
            err_cnt <= 3'd1;
          end
        end
        jesd_rx_pkg::CGS_CHECK: begin
          if (!err_beat) begin
            state   <= jesd_rx_pkg::CGS_DATA;  // Error run broken
            err_cnt <= '0;
          end else if (err_cnt == 3'(jesd_rx_pkg::CGS_LOSS_BEATS - 1)) begin
            state   <= jesd_rx_pkg::CGS_INIT;
            err_cnt <= '0;
          end else begin
            err_cnt <= err_cnt + 1'b1;
          end
        end
        default: state <= jesd_rx_pkg::CGS_INIT;
      endcase
    end
  end

  // Frame start latches on the first user data beat
  always_ff @(posedge clk) begin
    if (i_ifs_reset) begin
      frame_seen <= 1'b0;
    end else if (user_beat) begin
      frame_seen <= 1'b1;
    end
  end

  assign o_frame_start = frame_seen | (~i_ifs_reset & user_beat);
  assign o_cgs_ready   = (state == jesd_rx_pkg::CGS_DATA) || (state == jesd_rx_pkg::CGS_CHECK);
  assign o_cgs_state   = state;

endmodule

`default_nettype wire

//--- logic/lane_elastic_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lane_elastic_buffer (
  input  wire                                   clk,
  input  wire                                   i_ifs_reset,
  input  wire                                   i_frame_start,
  input  jesd_rx_pkg::beat_u                    i_data,
  input  wire                                   i_release_n,
  output logic                                  o_buffer_ready,
  output logic [jesd_rx_pkg::BEAT_BITS-1:0]     o_data
);

  logic [jesd_rx_pkg::BEAT_BITS-1:0] mem [jesd_rx_pkg::BUFFER_DEPTH];

  logic [jesd_rx_pkg::BUF_AW-1:0] wr_ptr;
  logic [jesd_rx_pkg::BUF_AW-1:0] rd_ptr;

  // Write side follows the lane's own frame start
  always_ff @(posedge clk) begin
    if (i_ifs_reset) begin
      wr_ptr         <= '0;
      o_buffer_ready <= 1'b0;
    end else if (i_frame_start) begin
      wr_ptr         <= wr_ptr + 1'b1;
      o_buffer_ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_frame_start) begin
      mem[wr_ptr] <= i_data.word;
    end
  end

  // Read side moves with the common release
  always_ff @(posedge clk) begin
    if (i_ifs_reset) begin
      rd_ptr <= '0;
    end else if (!i_release_n) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    o_data <= mem[rd_ptr];  // Registered read
  end

endmodule

`default_nettype wire

//--- logic/frame_mark.sv
`timescale 1ns/1ps
`default_nettype none

module frame_mark (
  input  wire                                        clk,
  input  wire                                        i_release_n,
  input  wire                                        i_valid,
  input  jesd_rx_pkg::rx_cfg_t                       i_cfg,
  output logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0]    o_sof,
  output logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0]    o_eof,
  output logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0]    o_somf,
  output logic [jesd_rx_pkg::OCTETS_PER_BEAT-1:0]    o_eomf
);

  localparam int W = jesd_rx_pkg::OCTETS_PER_BEAT;

  logic [9:0]     frame_size;
  logic [9:0]     frame_pos;  // Octet 0 position within the frame
  logic [9:0]     mf_pos;     // and within the multiframe
  logic [2*W-1:0] frame_marks;
  logic [2*W-1:0] mf_marks;

  // Start and end flags for the octets of one beat, end in the upper half
  function automatic logic [2*W-1:0] pos_marks(input logic [9:0] pos, input logic [9:0] size);
    logic [9:0]   p;
    logic [W-1:0] first;
    logic [W-1:0] last;
    first = '0;
    last  = '0;
    for (int k = 0; k < W; k++) begin
      p        = (pos + 10'(k)) % size;
      first[k] = (p == '0);
      last[k]  = (p == size - 1'b1);
    end
    return {last, first};
  endfunction

  assign frame_size = {2'b00, i_cfg.octets_per_frame};

  always_ff @(posedge clk) begin
    if (i_release_n) begin
      frame_pos <= '0;
      mf_pos    <= '0;
    end else if (i_valid) begin
      frame_pos <= (frame_pos + 10'(W)) % frame_size;
      mf_pos    <= (mf_pos + 10'(W)) % i_cfg.octets_per_multiframe;
    end
  end

  assign frame_marks = pos_marks(frame_pos, frame_size);
  assign mf_marks    = pos_marks(mf_pos, i_cfg.octets_per_multiframe);

  // Markers only on valid beats
  assign o_sof  = i_valid ? frame_marks[W-1:0]   : '0;
  assign o_eof  = i_valid ? frame_marks[2*W-1:W] : '0;
  assign o_somf = i_valid ? mf_marks[W-1:0]      : '0;
  assign o_eomf = i_valid ? mf_marks[2*W-1:W]    : '0;

endmodule

`default_nettype wire

//--- logic/jesd_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_top (
  input  wire                                                clk,
  input  wire                                                device_reset,
  input  jesd_rx_pkg::phy_lane_t [jesd_rx_pkg::NUM_LANES-1:0] i_phy,
  input  wire                                                i_sysref,
  input  jesd_rx_pkg::rx_cfg_t                               i_cfg,
  output logic                                               o_sync,
  output logic                                               o_lmfc_edge,
  output logic                                               o_sysref_alignment_error,
  output logic                                               o_unexpected_lane_state_error,
  output jesd_rx_pkg::rx_out_t                               o_rx,
  output jesd_rx_pkg::ctrl_state_e                           o_ctrl_state,
  output jesd_rx_pkg::cgs_state_e [jesd_rx_pkg::NUM_LANES-1:0] o_lane_cgs_state
);

  logic [jesd_rx_pkg::LMFC_W-1:0]    lmfc_counter;
  logic [jesd_rx_pkg::NUM_LANES-1:0] cgs_reset;
  logic [jesd_rx_pkg::NUM_LANES-1:0] cgs_ready;
  logic [jesd_rx_pkg::NUM_LANES-1:0] frame_start;
  logic [jesd_rx_pkg::NUM_LANES-1:0] buffer_ready;
  logic                              ifs_reset;
  logic                              release_n;

  lmfc_gen lmfc_gen_inst (
    .clk                      (clk),
    .device_reset             (device_reset),
    .i_sysref                 (i_sysref),
    .i_cfg                    (i_cfg),
    .o_lmfc_edge              (o_lmfc_edge),
    .o_lmfc_counter           (lmfc_counter),
    .o_sysref_alignment_error (o_sysref_alignment_error)
  );

  rx_link_ctrl rx_link_ctrl_inst (
    .clk                           (clk),
    .device_reset                  (device_reset),
    .i_cfg                         (i_cfg),
    .i_lmfc_edge                   (o_lmfc_edge),
    .i_lmfc_counter                (lmfc_counter),
    .i_cgs_ready                   (cgs_ready),
    .i_buffer_ready                (buffer_ready),
    .o_sync                        (o_sync),
    .o_cgs_reset                   (cgs_reset),
    .o_ifs_reset                   (ifs_reset),
    .o_release_n                   (release_n),
    .o_valid                       (o_rx.valid),
    .o_ctrl_state                  (o_ctrl_state),
    .o_unexpected_lane_state_error (o_unexpected_lane_state_error)
  );

  // ***********************************************************
  // Per-lane sync and buffering
  // ***********************************************************
  for (genvar i = 0; i < jesd_rx_pkg::NUM_LANES; i++) begin : gen_lane
    lane_cgs lane_cgs_inst (
      .clk           (clk),
      .i_cgs_reset   (cgs_reset[i]),
      .i_ifs_reset   (ifs_reset),
      .i_phy         (i_phy[i]),
      .o_cgs_ready   (cgs_ready[i]),
      .o_cgs_state   (o_lane_cgs_state[i]),
      .o_frame_start (frame_start[i])
    );

    lane_elastic_buffer lane_elastic_buffer_inst (
      .clk            (clk),
      .i_ifs_reset    (ifs_reset),
      .i_frame_start  (frame_start[i]),
      .i_data         (i_phy[i].data),
      .i_release_n    (release_n),
      .o_buffer_ready (buffer_ready[i]),
      .o_data         (o_rx.data[i])
    );
  end

  frame_mark frame_mark_inst (
    .clk         (clk),
    .i_release_n (release_n),
    .i_valid     (o_rx.valid),
    .i_cfg       (i_cfg),
    .o_sof       (o_rx.sof),
    .o_eof       (o_rx.eof),
    .o_somf      (o_rx.somf),
    .o_eomf      (o_rx.eomf)
  );

endmodule

`default_nettype wire

//--- verif/jesd_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_checker (
  input wire                      clk,
  input wire                      device_reset,
  input wire                      i_sync,
  input jesd_rx_pkg::ctrl_state_e i_state,
  input wire                      i_release_n,
  input wire                      i_lane_err
);

  // ***********************************************************
  // Link controller properties
  // ***********************************************************
  a_sync_only_when_up: assert property (@(posedge clk) disable iff (device_reset)
    !(i_state inside {jesd_rx_pkg::ST_IFS, jesd_rx_pkg::ST_DATA}) |-> !i_sync)
    else $error("SYNC high while the link is not up");

  a_lane_err_single: assert property (@(posedge clk) disable iff (device_reset)
    i_lane_err |=> !i_lane_err)
    else $error("Lane state event held for two cycles");

  // Release only while SYNC is high
  a_release_after_sync: assert property (@(posedge clk) disable iff (device_reset)
    $fell(i_release_n) |-> i_sync)
    else $error("Buffer release while SYNC low");

endmodule

bind rx_link_ctrl jesd_rx_checker checker_inst (
  .clk          (clk),
  .device_reset (device_reset),
  .i_sync       (o_sync),
  .i_state      (o_ctrl_state),
  .i_release_n  (o_release_n),
  .i_lane_err   (o_unexpected_lane_state_error)
);

`default_nettype wire

//--- verif/jesd_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module jesd_rx_tb;

  localparam int NL            = jesd_rx_pkg::NUM_LANES;
  localparam int PAYLOAD_BEATS = 20;
  localparam int NUM_CASES     = 3;
  localparam int HIST          = 4096;

  typedef struct {
    jesd_rx_pkg::rx_cfg_t cfg;
    int                   err_lane;        // -1 for no injected loss
    int                   exp_period;      // LMFC period in beats
    int                   exp_align_errs;
    int                   exp_lane_errs;
  } case_t;

  logic                                   clk;
  logic                                   device_reset;
  jesd_rx_pkg::phy_lane_t [NL-1:0]        phy;
  logic                                   sysref;
  jesd_rx_pkg::rx_cfg_t                   cfg;
  logic                                   o_sync;
  logic                                   o_lmfc_edge;
  logic                                   o_sysref_alignment_error;
  logic                                   o_unexpected_lane_state_error;
  jesd_rx_pkg::rx_out_t                   o_rx;
  jesd_rx_pkg::ctrl_state_e               o_ctrl_state;
  jesd_rx_pkg::cgs_state_e [NL-1:0]       o_lane_cgs_state;

  case_t       cases [NUM_CASES];
  case_t       cur;
  logic [31:0] pay_q [NL][$];  // Payload per lane, in send order
  int          hist [HIST];    // Reconstructed LMFC counter per cycle
  int          cycles;
  int          limit;
  int          cyc;
  int          recon;
  int          n_out;
  int          align_errs;
  int          lane_errs;
  int          edges_since_sync;
  bit          first_valid;

  jesd_rx_top jesd_rx_top_inst (
    .clk                           (clk),
    .device_reset                  (device_reset),
    .i_phy                         (phy),
    .i_sysref                      (sysref),
    .i_cfg                         (cfg),
    .o_sync                        (o_sync),
    .o_lmfc_edge                   (o_lmfc_edge),
    .o_sysref_alignment_error      (o_sysref_alignment_error),
    .o_unexpected_lane_state_error (o_unexpected_lane_state_error),
    .o_rx                          (o_rx),
    .o_ctrl_state                  (o_ctrl_state),
    .o_lane_cgs_state              (o_lane_cgs_state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Something failed");
      $fatal(1, "Stopped by timeout");
    end
  end

  // ***********************************************************
  // Checks
  // ***********************************************************
  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_rx(input jesd_rx_pkg::rx_out_t got, input jesd_rx_pkg::rx_out_t exp);
    if (got !== exp) begin
      $display("MISMATCH o_rx: got %h expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_state(input jesd_rx_pkg::ctrl_state_e got,
                             input jesd_rx_pkg::ctrl_state_e exp);
    if (got !== exp) begin
      $display("MISMATCH o_ctrl_state: got %h expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_cgs(input jesd_rx_pkg::cgs_state_e got,
                           input jesd_rx_pkg::cgs_state_e exp, input int lane);
    if (got !== exp) begin
      $display("MISMATCH o_lane_cgs_state[%0d]: got %h expected %h", lane, got, exp);
      stop_run();
    end
  endtask

  task automatic check_int(input int got, input int exp, input string name);
    if (got != exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // Expected beat from the octet numbering rule
  function automatic jesd_rx_pkg::rx_out_t expected_beat(input int idx);
    jesd_rx_pkg::rx_out_t exp;
    int n;
    int opf;
    int opm;
    exp       = '0;
    exp.valid = 1'b1;
    opf       = int'(cur.cfg.octets_per_frame);
    opm       = int'(cur.cfg.octets_per_multiframe);
    for (int l = 0; l < NL; l++) begin
      if (!cur.cfg.lanes_disable[l]) exp.data[l] = pay_q[l].pop_front();
    end
    for (int k = 0; k < jesd_rx_pkg::OCTETS_PER_BEAT; k++) begin
      n            = 4 * idx + k;
      exp.sof[k]   = (n % opf) == 0;
      exp.eof[k]   = (n % opf) == opf - 1;
      exp.somf[k]  = (n % opm) == 0;
      exp.eomf[k]  = (n % opm) == opm - 1;
    end
    return exp;
  endfunction

  task automatic check_release();
    if (cur.cfg.buffer_early_release) begin
      if (edges_since_sync != 0) begin
        $display("Early release: valid did not rise before the next LMFC edge");
        stop_run();
      end
    end else begin
      check_int(hist[(cyc - 2) % HIST], int'(cur.cfg.buffer_delay), "lmfc_counter at release");
    end
  endtask

  // ***********************************************************
  // One cycle: sample outputs at the falling edge
  // ***********************************************************
  task automatic tick();
    jesd_rx_pkg::rx_out_t got;
    jesd_rx_pkg::rx_out_t exp;
    @(negedge clk);
    cyc++;
    recon = o_lmfc_edge ? 0 : (recon + 1) % cur.exp_period;
    hist[cyc % HIST] = recon;
    if (o_sysref_alignment_error) align_errs++;
    if (o_unexpected_lane_state_error) lane_errs++;
    if (o_sync && o_lmfc_edge && !first_valid) edges_since_sync++;
    if (o_rx.valid && n_out < PAYLOAD_BEATS) begin
      if (!first_valid) check_release();
      first_valid = 1'b1;
      got = o_rx;
      exp = expected_beat(n_out);
      for (int l = 0; l < NL; l++) begin
        if (cur.cfg.lanes_disable[l]) begin
          got.data[l] = '0;
          exp.data[l] = '0;
        end
      end
      check_rx(got, exp);
      n_out++;
    end
  endtask

  task automatic drive_lanes(input bit user, input bit record, input int err_lane);
    for (int l = 0; l < NL; l++) begin
      if (cur.cfg.lanes_disable[l]) begin
        phy[l].data.word  = $urandom;  // Garbage on a disabled lane
        phy[l].charisk    = 4'($urandom);
        phy[l].disperr    = 4'($urandom);
        phy[l].notintable = 4'($urandom);
      end else if (!user) begin
        phy[l].data.word  = {4{jesd_rx_pkg::K28_5}};
        phy[l].charisk    = 4'hF;
        phy[l].disperr    = 4'h0;
        phy[l].notintable = 4'h0;
      end else begin
        phy[l].data.word  = $urandom;
        phy[l].charisk    = 4'h0;
        phy[l].disperr    = (l == err_lane) ? 4'hF : 4'h0;
        phy[l].notintable = 4'h0;
        if (record) pay_q[l].push_back(phy[l].data.word);
      end
    end
  endtask

  task automatic run_case(input int c);
    int n;
    int cgs_cycles;
    int cnt;
    cur = cases[c];
    cfg = cur.cfg;
    for (int l = 0; l < NL; l++) pay_q[l].delete();
    device_reset = 1'b1;
    sysref       = 1'b0;
    drive_lanes(1'b0, 1'b0, -1);
    repeat (4) tick();
    check_state(o_ctrl_state, jesd_rx_pkg::ST_RESET);
    check_int(o_sync, 0, "o_sync");
    device_reset     = 1'b0;
    align_errs       = 0;
    lane_errs        = 0;
    n_out            = 0;
    edges_since_sync = 0;
    first_valid      = 1'b0;
    n                = 0;
    cgs_cycles       = 0;
    tick();
    while (!o_sync) begin
      if (o_ctrl_state == jesd_rx_pkg::ST_CGS) cgs_cycles++;
      n++;
      sysref = (n == 2);
      drive_lanes(1'b0, 1'b0, -1);
      tick();
    end
    sysref = 1'b0;
    if (cgs_cycles < jesd_rx_pkg::CGS_GOOD_BEATS) begin
      $display("SYNC rose after only %0d comma cycles", cgs_cycles);
      stop_run();
    end
    check_state(o_ctrl_state, jesd_rx_pkg::ST_IFS);
    for (int l = 0; l < NL; l++) begin
      if (!cur.cfg.lanes_disable[l]) check_cgs(o_lane_cgs_state[l], jesd_rx_pkg::CGS_DATA, l);
    end
    // Payload, then filler until every payload beat came out
    for (int i = 0; i < PAYLOAD_BEATS; i++) begin
      drive_lanes(1'b1, 1'b1, -1);
      tick();
    end
    while (n_out < PAYLOAD_BEATS) begin
      drive_lanes(1'b1, 1'b0, -1);
      tick();
    end
    while (!o_lmfc_edge) begin
      drive_lanes(1'b1, 1'b0, -1);
      tick();
    end
    repeat (3) begin
      cnt = 0;
      do begin
        drive_lanes(1'b1, 1'b0, -1);
        tick();
        cnt++;
      end while (!o_lmfc_edge);
      check_int(cnt, cur.exp_period, "o_lmfc_edge period");
    end
    // Second SYSREF off the running phase
    while (recon != int'(cur.cfg.lmfc_offset)) begin
      drive_lanes(1'b1, 1'b0, -1);
      tick();
    end
    sysref = 1'b1;
    drive_lanes(1'b1, 1'b0, -1);
    tick();
    sysref = 1'b0;
    repeat (8) begin
      drive_lanes(1'b1, 1'b0, -1);
      tick();
    end
    check_int(align_errs, cur.exp_align_errs, "o_sysref_alignment_error pulses");
    if (cur.err_lane >= 0) begin
      repeat (3) begin
        drive_lanes(1'b1, 1'b0, cur.err_lane);
        tick();
      end
      repeat (6) begin
        drive_lanes(1'b1, 1'b0, -1);
        tick();
      end
      check_state(o_ctrl_state, jesd_rx_pkg::ST_CGS);
      check_int(o_sync, 0, "o_sync");
      check_cgs(o_lane_cgs_state[cur.err_lane], jesd_rx_pkg::CGS_INIT, cur.err_lane);
    end
    check_int(lane_errs, cur.exp_lane_errs, "o_unexpected_lane_state_error pulses");
  endtask

  function automatic case_t make_case(input logic [1:0] dis, input int opf, input int opm,
                                      input int offset, input int delay, input bit early,
                                      input int err_lane);
    case_t t;
    t.cfg.lanes_disable         = dis;
    t.cfg.octets_per_frame      = 8'(opf);
    t.cfg.octets_per_multiframe = 10'(opm);
    t.cfg.lmfc_offset           = 8'(offset);
    t.cfg.buffer_delay          = 8'(delay);
    t.cfg.buffer_early_release  = early;
    t.err_lane                  = err_lane;
    t.exp_period                = opm / 4;
    t.exp_align_errs            = 1;
    t.exp_lane_errs             = (err_lane >= 0) ? 1 : 0;
    return t;
  endfunction

  initial begin
    void'($urandom(32'h782a277e));
    cycles       = 0;
    cyc          = 0;
    recon        = 0;
    device_reset = 1'b1;
    sysref       = 1'b0;
    phy          = '0;
    cfg          = '0;
    // Stimulus table: frame size, multiframe, offset, delay, early, error lane
    cases[0] = make_case(2'b00, 1, 16, 0, 2, 1'b0, -1);
    cases[1] = make_case(2'b10, 2, 32, 3, 5, 1'b0, 0);
    cases[2] = make_case(2'b00, 4, 32, 1, 0, 1'b1, 1);
    limit = 200;
    for (int c = 0; c < NUM_CASES; c++) begin
      limit += 40 + 2 * PAYLOAD_BEATS + 8 * cases[c].exp_period + 32;
    end
    @(posedge clk);  // Start on a running clock
    for (int c = 0; c < NUM_CASES; c++) run_case(c);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- jesd_rx.f
logic/jesd_rx_pkg.sv
logic/lmfc_gen.sv
logic/rx_link_ctrl.sv
logic/lane_cgs.sv
logic/lane_elastic_buffer.sv
logic/frame_mark.sv
logic/jesd_rx_top.sv
verif/jesd_rx_checker.sv
verif/jesd_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= jesd_rx_tb
FILELIST  ?= jesd_rx.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
